// File: design/elevator_cfg.svh
//////////////////////////////////////////////////////////////////////
// Elevator floor request configuration
// Floor count, field widths, stop-state range and stack depth
//////////////////////////////////////////////////////////////////////

`ifndef ELEVATOR_CFG_SVH
`define ELEVATOR_CFG_SVH

// Building size and floor number width
`define NUM_FLOORS  11
`define FLOOR_W     4

// Car state code from the motion FSM
`define STATE_W     6
// Codes 0 to STOP_LAST mean stopped at floor n+1
`define STOP_LAST   10

// Request stack
`define STACK_DEPTH 11

`endif

// File: design/elevator_pkg.sv
//////////////////////////////////////////////////////////////////////
// Elevator floor request package
// Shared floor, button, request and command types
//////////////////////////////////////////////////////////////////////

`include "elevator_cfg.svh"

package elevator_pkg;

    // Floor number where floor 1 is code 0
    typedef logic [`FLOOR_W-1:0] floor_t;

    // One bit per floor
    typedef logic [`NUM_FLOORS-1:0] button_vec_t;

    // Car state code as reported by the motion FSM
    typedef logic [`STATE_W-1:0] state_code_t;

    typedef struct packed {
        floor_t      floor;
        state_code_t state;
        logic        direction;  // 1 is up
    } car_status_t;

    // Hall call and car panel buttons and their lamps
    typedef struct packed {
        button_vec_t call;
        button_vec_t panel;
    } button_set_t;

    // Candidate request picked by the scanner
    typedef struct packed {
        logic   valid;
        floor_t floor;
        logic   from_panel;
    } request_t;

    // Stack commands with at most one set per cycle
    typedef struct packed {
        logic push;
        logic pop;
        logic flush;
    } stack_cmd_t;

    // Target sent to the motion controller
    typedef struct packed {
        floor_t floor;
        logic   direction;
        logic   activate;
    } dispatch_t;

    typedef struct packed {
        logic open_allowed;
        logic close_allowed;
    } door_t;

endpackage

// File: design/request_control.sv
//////////////////////////////////////////////////////////////////////
// Request control
// Picks flush, pop or push each cycle, drives dispatch and door gating
//////////////////////////////////////////////////////////////////////

`include "elevator_cfg.svh"

module request_control (
    input  elevator_pkg::request_t    request,
    input  elevator_pkg::floor_t      top,
    input  logic                      empty,
    input  logic                      full,
    input  logic                      power,
    input  logic                      emergency,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    input  elevator_pkg::car_status_t car,
    output elevator_pkg::stack_cmd_t  cmd,
    output elevator_pkg::dispatch_t   dispatch,
    output elevator_pkg::door_t       doors
);

    import elevator_pkg::*;

    logic stopped;
    logic running;
    logic at_top;

    // Stop states occupy the low end of the state code range
    assign stopped = (car.state <= state_code_t'(`STOP_LAST));
    assign running = power && !emergency;
    assign at_top  = !empty && (top == car.floor);

    //////////////////////////////////////////////////////////////////////
    // Stack commands
    //////////////////////////////////////////////////////////////////////

    // Flush wins over pop, pop wins over push
    always_comb begin
        cmd.flush = !running;
        cmd.pop   = running && stopped && at_top;
        cmd.push  = running && !cmd.pop && request.valid && !full;
    end

    //////////////////////////////////////////////////////////////////////
    // Dispatch to the motion controller
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Hold position by default
        dispatch.floor     = car.floor;
        dispatch.direction = car.direction;
        dispatch.activate  = 1'b0;

        if (running && stopped && !empty) begin
            dispatch.floor    = top;
            dispatch.activate = (top != car.floor);
            if (top > car.floor) begin
                dispatch.direction = 1'b1;
            end else if (top < car.floor) begin
                dispatch.direction = 1'b0;
            end
        end
    end

    // Door buttons only pass while parked with power on
    always_comb begin
        doors.open_allowed  = 1'b0;
        doors.close_allowed = 1'b0;
        if (stopped && power) begin
            doors.open_allowed  = door_open_button;
            doors.close_allowed = door_close_button;
        end
    end

endmodule

// File: design/button_scanner.sv
//////////////////////////////////////////////////////////////////////
// Button scanner
// Selects at most one new request from the panel and hall call buttons
//////////////////////////////////////////////////////////////////////

`include "elevator_cfg.svh"

module button_scanner (
    input  elevator_pkg::button_set_t buttons,
    input  elevator_pkg::button_set_t lamps,
    input  elevator_pkg::floor_t      current_floor,
    output elevator_pkg::request_t    request
);

    import elevator_pkg::*;

    button_vec_t here_mask;
    button_vec_t live_panel;
    button_vec_t live_call;

    // Lowest set bit of a button vector as a floor number
    function automatic floor_t lowest_floor(input button_vec_t vec);
        floor_t sel;
        sel = '0;
        // Walk down so the lowest floor is written last
        for (int i = `NUM_FLOORS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                sel = floor_t'(i);
            end
        end
        return sel;
    endfunction

    // One-hot of the floor the car is at
    assign here_mask = button_vec_t'(1) << current_floor;

    // Drop presses for this floor and for floors already lit
    assign live_panel = buttons.panel & ~lamps.panel & ~here_mask;
    assign live_call  = buttons.call  & ~lamps.call  & ~here_mask;

    always_comb begin
        request.valid      = (|live_panel) || (|live_call);
        request.from_panel = |live_panel;
        // Panel buttons take priority over hall calls
        if (request.from_panel) begin
            request.floor = lowest_floor(live_panel);
        end else begin
            request.floor = lowest_floor(live_call);
        end
    end

endmodule

// File: design/button_lamps.sv
//////////////////////////////////////////////////////////////////////
// Button lamps
// Call and panel lamp registers, set on accept and cleared on service
//////////////////////////////////////////////////////////////////////

module button_lamps (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::stack_cmd_t  cmd,
    input  elevator_pkg::request_t    request,
    input  elevator_pkg::floor_t      current_floor,
    output elevator_pkg::button_set_t lamps
);

    import elevator_pkg::*;

    button_vec_t served_mask;
    button_vec_t accept_mask;

    assign served_mask = button_vec_t'(1) << current_floor;
    assign accept_mask = button_vec_t'(1) << request.floor;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lamps <= '0;
        end else if (cmd.flush) begin
            lamps <= '0;
        end else if (cmd.pop) begin
            // Both lamps of the served floor go dark
            lamps.call  <= lamps.call  & ~served_mask;
            lamps.panel <= lamps.panel & ~served_mask;
        end else if (cmd.push) begin
            if (request.from_panel) begin
                lamps.panel <= lamps.panel | accept_mask;
            end else begin
                lamps.call <= lamps.call | accept_mask;
            end
        end
    end

endmodule

// File: design/request_stack.sv
//////////////////////////////////////////////////////////////////////
// Request stack
// LIFO of accepted floor numbers with full, empty and top of stack
//////////////////////////////////////////////////////////////////////

`include "elevator_cfg.svh"

module request_stack (
    input  logic                     clock,
    input  logic                     reset_n,
    input  elevator_pkg::stack_cmd_t cmd,
    input  elevator_pkg::floor_t     push_floor,
    output elevator_pkg::floor_t     top,
    output logic                     empty,
    output logic                     full
);

    import elevator_pkg::*;

    // Pointer counts entries from 0 up to STACK_DEPTH
    localparam int PTR_W = $clog2(`STACK_DEPTH + 1);

    floor_t             entries [`STACK_DEPTH];
    logic   [PTR_W-1:0] ptr;

    //////////////////////////////////////////////////////////////////////
    // Pointer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ptr <= '0;
        end else if (cmd.flush) begin
            ptr <= '0;
        end else if (cmd.pop && !empty) begin
            ptr <= ptr - 1'b1;
        end else if (cmd.push && !full) begin
            ptr <= ptr + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    // Push writes the free slot above the current top
    always_ff @(posedge clock) begin
        if (cmd.push && !full && !cmd.pop && !cmd.flush) begin
            entries[ptr] <= push_floor;
        end
    end

    assign empty = (ptr == '0);
    assign full  = (ptr == PTR_W'(`STACK_DEPTH));

    // Most recent entry sits one below the pointer
    always_comb begin
        if (empty) begin
            top = '0;
        end else begin
            top = entries[ptr - 1'b1];
        end
    end

endmodule

// File: design/floor_request_top.sv
//////////////////////////////////////////////////////////////////////
// Floor request controller top level
// Connects control, button scanner, lamp registers and request stack
//////////////////////////////////////////////////////////////////////

module floor_request_top (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::button_set_t buttons,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    input  logic                      emergency,
    input  logic                      power,
    input  elevator_pkg::car_status_t car,
    output elevator_pkg::button_set_t lamps,
    output elevator_pkg::dispatch_t   dispatch,
    output elevator_pkg::door_t       doors
);

    import elevator_pkg::*;

    // Scanner to control and datapath
    request_t   request;

    // Control to datapath
    stack_cmd_t cmd;

    // Stack status back to control
    floor_t     top;
    logic       empty;
    logic       full;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    request_control i_request_control (
        .request           (request),
        .top               (top),
        .empty             (empty),
        .full              (full),
        .power             (power),
        .emergency         (emergency),
        .door_open_button  (door_open_button),
        .door_close_button (door_close_button),
        .car               (car),
        .cmd               (cmd),
        .dispatch          (dispatch),
        .doors             (doors)
    );

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    button_scanner i_button_scanner (
        .buttons       (buttons),
        .lamps         (lamps),
        .current_floor (car.floor),
        .request       (request)
    );

    button_lamps i_button_lamps (
        .clock         (clock),
        .reset_n       (reset_n),
        .cmd           (cmd),
        .request       (request),
        .current_floor (car.floor),
        .lamps         (lamps)
    );

    request_stack i_request_stack (
        .clock      (clock),
        .reset_n    (reset_n),
        .cmd        (cmd),
        .push_floor (request.floor),
        .top        (top),
        .empty      (empty),
        .full       (full)
    );

endmodule

// File: dv/floor_request_tb.sv
//////////////////////////////////////////////////////////////////////
// Floor request controller testbench
// Replays a per-cycle trace of inputs and expected outputs on the DUT
//////////////////////////////////////////////////////////////////////

module floor_request_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import elevator_pkg::*;

    localparam string TRACE_PATH = "dv/floor_request_trace.txt";

    // One trace line with inputs first and then the expected outputs
    typedef struct packed {
        button_set_t buttons;
        logic [1:0]  door_buttons;
        logic        emergency;
        logic        power;
        car_status_t car;
        button_set_t exp_lamps;
        dispatch_t   exp_dispatch;
        door_t       exp_doors;
    } trace_line_t;

    logic        clock = 1'b0;
    logic        reset_n;
    button_set_t buttons;
    logic        door_open_button;
    logic        door_close_button;
    logic        emergency;
    logic        power;
    car_status_t car;
    button_set_t lamps;
    dispatch_t   dispatch;
    door_t       doors;

    trace_line_t trace [$];
    int          line_no;
    int          cycles = 0;
    int          cycle_limit = 1000;
    int          dispatch_errors = 0;
    int          lamp_errors = 0;
    int          door_errors = 0;

    floor_request_top i_floor_request_top (
        .clock             (clock),
        .reset_n           (reset_n),
        .buttons           (buttons),
        .door_open_button  (door_open_button),
        .door_close_button (door_close_button),
        .emergency         (emergency),
        .power             (power),
        .car               (car),
        .lamps             (lamps),
        .dispatch          (dispatch),
        .doors             (doors)
    );

    initial begin
        forever #4 clock = ~clock;
    end

    // Run limit from the trace length
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Trace reading and driving
    //////////////////////////////////////////////////////////////////////

    task automatic load_trace(output bit ok);
        int          fd;
        int          status;
        int          fields;
        string       text;
        trace_line_t entry;
        int          panel, call, door_btn, emerg, pwr, car_floor, car_state, car_dir;
        int          exp_panel, exp_call, exp_floor, exp_dir, exp_act, exp_door;
        ok = 1'b0;
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            $display("Cannot open the trace file %s", TRACE_PATH);
        end else begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                status = $fgets(text, fd);
                if (status == 0) begin
                    break;
                end
                // Comment and blank lines carry no cycle
                if (text.len() > 1 && text.getc(0) != "/") begin
                    fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                     panel, call, door_btn, emerg, pwr, car_floor,
                                     car_state, car_dir, exp_panel, exp_call,
                                     exp_floor, exp_dir, exp_act, exp_door);
                    if (fields != 14) begin
                        $display("Trace line has %0d fields instead of 14: %s", fields, text);
                        ok = 1'b0;
                    end else begin
                        entry.buttons.panel          = button_vec_t'(panel);
                        entry.buttons.call           = button_vec_t'(call);
                        entry.door_buttons           = door_btn[1:0];
                        entry.emergency              = emerg[0];
                        entry.power                  = pwr[0];
                        entry.car.floor              = floor_t'(car_floor);
                        entry.car.state              = state_code_t'(car_state);
                        entry.car.direction          = car_dir[0];
                        entry.exp_lamps.panel        = button_vec_t'(exp_panel);
                        entry.exp_lamps.call         = button_vec_t'(exp_call);
                        entry.exp_dispatch.floor     = floor_t'(exp_floor);
                        entry.exp_dispatch.direction = exp_dir[0];
                        entry.exp_dispatch.activate  = exp_act[0];
                        entry.exp_doors.open_allowed  = exp_door[1];
                        entry.exp_doors.close_allowed = exp_door[0];
                        trace.push_back(entry);
                    end
                end
            end
            $fclose(fd);
            if (trace.size() == 0) begin
                $display("The trace file holds no stimulus lines");
                ok = 1'b0;
            end
        end
    endtask

    task automatic drive_inputs(input trace_line_t t);
        buttons           = t.buttons;
        door_open_button  = t.door_buttons[1];
        door_close_button = t.door_buttons[0];
        emergency         = t.emergency;
        power             = t.power;
        car               = t.car;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_dispatch(input dispatch_t actual, input dispatch_t expected);
        if (actual !== expected) begin
            dispatch_errors++;
            $display("CHECK FAILED time %0t line %0d dispatch: ", $time, line_no,
                     "expected floor %0d dir %0b act %0b, ", expected.floor,
                     expected.direction, expected.activate,
                     "actual floor %0d dir %0b act %0b", actual.floor,
                     actual.direction, actual.activate);
        end
    endtask

    task automatic check_lamps(input button_set_t actual, input button_set_t expected);
        if (actual !== expected) begin
            lamp_errors++;
            $display("CHECK FAILED time %0t line %0d lamps: ", $time, line_no,
                     "expected panel %h call %h, ", expected.panel, expected.call,
                     "actual panel %h call %h", actual.panel, actual.call);
        end
    endtask

    task automatic check_doors(input door_t actual, input door_t expected);
        if (actual !== expected) begin
            door_errors++;
            $display("CHECK FAILED time %0t line %0d doors: ", $time, line_no,
                     "expected open %0b close %0b, ", expected.open_allowed,
                     expected.close_allowed, "actual open %0b close %0b",
                     actual.open_allowed, actual.close_allowed);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        bit loaded;
        int total;
        reset_n           = 1'b0;
        buttons           = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency         = 1'b0;
        power             = 1'b1;
        car               = '0;
        load_trace(loaded);
        if (!loaded) begin
            $display("Stopping because the trace could not be used");
            $display("Errors found");
            $finish;
        end else begin
            cycle_limit = trace.size() + 20;
            repeat (2) @(negedge clock);
            reset_n = 1'b1;
            drive_inputs(trace[0]);
            // Outputs of a line are checked after the edge that took its inputs
            for (int i = 1; i <= trace.size(); i++) begin
                @(negedge clock);
                line_no = i - 1;
                check_lamps(lamps, trace[i-1].exp_lamps);
                check_dispatch(dispatch, trace[i-1].exp_dispatch);
                check_doors(doors, trace[i-1].exp_doors);
                if (i < trace.size()) begin
                    drive_inputs(trace[i]);
                end
            end
            total = dispatch_errors + lamp_errors + door_errors;
            $display("Lines %0d, dispatch errors %0d, lamp errors %0d, door errors %0d, total %0d",
                     trace.size(), dispatch_errors, lamp_errors, door_errors, total);
            if (total == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

endmodule

// File: dv/floor_request_trace.txt
// In: panel call door(open,close) emergency power floor state dir
// Out after the edge: lamp_panel lamp_call disp_floor disp_dir activate doors(open,close)
// Accept and light
000 000 0 0 1 0 00 0   000 000 0 0 0 0
008 000 0 0 1 0 00 0   008 000 3 1 1 0
009 000 0 0 1 0 00 0   008 000 3 1 1 0
008 001 0 0 1 0 00 0   008 000 3 1 1 0
// Priority and LIFO order
0a0 202 0 0 1 0 00 0   028 000 5 1 1 0
0a0 202 0 0 1 0 00 0   0a8 000 7 1 1 0
0a0 202 0 0 1 0 00 0   0a8 002 1 1 1 0
0a0 202 0 0 1 0 00 0   0a8 202 9 1 1 0
0a0 202 0 0 1 0 00 0   0a8 202 9 1 1 0
000 000 0 0 1 0 00 0   0a8 202 9 1 1 0
// Moving, service and doors
000 000 2 0 1 4 20 1   0a8 202 4 1 0 0
000 000 3 0 1 8 20 1   0a8 202 8 1 0 0
000 000 0 0 1 9 09 1   0a8 002 1 0 1 0
000 000 3 0 1 9 09 1   0a8 002 1 0 1 3
000 000 2 0 1 9 09 1   0a8 002 1 0 1 2
000 000 1 0 1 5 21 0   0a8 002 5 0 0 0
000 000 0 0 1 1 01 0   0a8 000 7 1 1 0
002 000 0 0 1 1 01 0   0a8 000 7 1 1 0
// Flush by emergency, then by power loss
040 000 0 1 1 1 01 0   000 000 1 0 0 0
040 000 2 1 1 1 01 0   000 000 1 0 0 2
000 000 0 0 1 1 01 0   000 000 1 0 0 0
040 000 0 0 1 1 01 0   040 000 6 1 1 0
000 000 3 0 0 1 01 0   000 000 1 0 0 0
000 000 0 0 1 1 01 0   000 000 1 0 0 0
// Fill the stack to eleven entries
7ff 001 0 0 1 1 01 0   001 000 0 0 1 0
7ff 001 0 0 1 1 01 0   005 000 2 1 1 0
7ff 001 0 0 1 1 01 0   00d 000 3 1 1 0
7ff 001 0 0 1 1 01 0   01d 000 4 1 1 0
7ff 001 0 0 1 1 01 0   03d 000 5 1 1 0
7ff 001 0 0 1 1 01 0   07d 000 6 1 1 0
7ff 001 0 0 1 1 01 0   0fd 000 7 1 1 0
7ff 001 0 0 1 1 01 0   1fd 000 8 1 1 0
7ff 001 0 0 1 1 01 0   3fd 000 9 1 1 0
7ff 001 0 0 1 1 01 0   7fd 000 a 1 1 0
7ff 001 0 0 1 1 01 0   7fd 001 0 0 1 0
// Full stack ignores presses until a service frees a slot
000 004 0 0 1 1 01 0   7fd 001 0 0 1 0
000 004 0 0 1 0 00 0   7fc 000 a 1 1 0
000 004 0 0 1 0 00 0   7fc 004 2 1 1 0
000 008 0 0 1 0 00 0   7fc 004 2 1 1 0
000 008 0 0 1 2 02 1   7f8 000 a 1 1 0
000 008 0 0 1 2 02 1   7f8 008 3 1 1 0
000 000 0 0 1 2 02 1   7f8 008 3 1 1 0
000 000 3 0 1 3 3f 1   7f8 008 3 1 0 0
000 000 0 0 1 3 03 1   7f0 000 a 1 1 0
000 000 1 1 1 3 03 1   000 000 3 1 0 1

// File: verilog.f
+incdir+design
design/elevator_pkg.sv
design/request_control.sv
design/button_scanner.sv
design/button_lamps.sv
design/request_stack.sv
design/floor_request_top.sv
dv/floor_request_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the floor request testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module floor_request_tb -o floor_request_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/floor_request_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# The testbench prints the pass line on its own
if echo "$output" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi
